// ==== source/csr_pkg.sv ====
// Shared types and constants for the machine-mode CSR block
// Only RV32 is supported, XLEN is fixed at 32
// Unmapped CSR numbers are not listed here and decode as illegal
package csr_pkg;

	localparam int XLEN = 32;

	typedef logic [XLEN-1:0] xlen_t;     // CSR data and addresses
	typedef logic [11:0]     csr_addr_t; // CSR number

	// --------------------
	// CSR numbers
	localparam csr_addr_t ADDR_MSTATUS       = 12'h300;
	localparam csr_addr_t ADDR_MIE           = 12'h304;
	localparam csr_addr_t ADDR_MTVEC         = 12'h305;
	localparam csr_addr_t ADDR_MCOUNTINHIBIT = 12'h320; // Standard number
	localparam csr_addr_t ADDR_MEPC          = 12'h341;
	localparam csr_addr_t ADDR_MCAUSE        = 12'h342;
	localparam csr_addr_t ADDR_MTVAL         = 12'h343;
	localparam csr_addr_t ADDR_MIP           = 12'h344;
	localparam csr_addr_t ADDR_MCYCLE        = 12'hb00;
	localparam csr_addr_t ADDR_MINSTRET      = 12'hb02;
	localparam csr_addr_t ADDR_MCYCLEH       = 12'hb80;
	localparam csr_addr_t ADDR_MINSTRETH     = 12'hb82;
	localparam csr_addr_t ADDR_MEIE0         = 12'hbe0; // Custom, external enables
	localparam csr_addr_t ADDR_MEIP0         = 12'hfe0; // Custom, read-only pending
	localparam csr_addr_t ADDR_MLEI          = 12'hfe4; // Custom, read-only lowest IRQ

	localparam xlen_t MIE_WMASK = 32'h0000_0888; // MEIE, MTIE, MSIE

	typedef enum logic [1:0] {
		WTYPE_W = 2'd0, // Plain write
		WTYPE_S = 2'd1, // Set bits
		WTYPE_C = 2'd2  // Clear bits
	} wtype_t;

	// Exception number doubles as its mcause code
	typedef enum logic [3:0] {
		EXCEPT_INSTR_MISALIGN = 4'd0,
		EXCEPT_INSTR_FAULT    = 4'd1,
		EXCEPT_INSTR_ILLEGAL  = 4'd2,
		EXCEPT_EBREAK         = 4'd3,
		EXCEPT_LOAD_ALIGN     = 4'd4,
		EXCEPT_LOAD_FAULT     = 4'd5,
		EXCEPT_STORE_ALIGN    = 4'd6,
		EXCEPT_STORE_FAULT    = 4'd7,
		EXCEPT_MRET           = 4'd11, // Trap exit, not a real exception
		EXCEPT_NONE           = 4'd15
	} except_t;

	typedef struct packed {
		csr_addr_t addr;
		xlen_t     wdata;
		wtype_t    wtype;
		logic      wen; // Write at next edge
		logic      ren; // Read this cycle
	} csr_req_t;

	typedef struct packed {
		logic       mstatus_mie;
		logic       mstatus_mpie;
		xlen_t      mtvec;         // Bit 0 is MODE, bit 1 always 0
		logic       vector_enable;
		xlen_t      mepc;
		logic       mcause_irq;
		logic [5:0] mcause_code;
		xlen_t      mie;
		xlen_t      meie0;
	} trap_state_t;

	// Write/set/clear of one CSR, bits outside wmask keep their old value
	function automatic xlen_t csr_update(xlen_t prev, xlen_t wdata, wtype_t wtype,
		xlen_t wmask);
		xlen_t nxt;
		case (wtype)
			WTYPE_S: nxt = prev | wdata;
			WTYPE_C: nxt = prev & ~wdata;
			default: nxt = wdata;
		endcase
		return (nxt & wmask) | (prev & ~wmask);
	endfunction

endpackage

// ==== source/csr_trap_regs.sv ====
// Trap CSRs: mstatus (MIE/MPIE), mtvec, mepc, mcause, mie and meie0
// A taken trap wins over a CSR write to the same register in that cycle
// mcause keeps 6 code bits, only bits 4:0 are visible on a read
`timescale 1ns/10ps

module csr_trap_regs #(
	parameter int            NUM_IRQ    = 8,
	parameter csr_pkg::xlen_t MTVEC_INIT = '0
) (
	input  logic                 clk,
	input  logic                 rst_n,
	input  csr_pkg::csr_req_t    req,
	input  csr_pkg::except_t     except,
	input  csr_pkg::xlen_t       mepc_in,
	input  logic                 trap_take,
	input  logic                 cause_irq_next,
	input  logic [5:0]           cause_code_next,
	output csr_pkg::trap_state_t state
);
	import csr_pkg::*;

	// --------------------
	// Writable bit masks
	localparam xlen_t MSTATUS_WMASK = 32'h0000_0088;   // MPIE, MIE
	localparam xlen_t MTVEC_WMASK   = ~32'h0000_0002;  // Bit 1 reserved
	localparam xlen_t MEPC_WMASK    = ~32'h0000_0001;  // Halfword aligned
	localparam xlen_t MCAUSE_WMASK  = 32'h8000_003f;   // IRQ flag and code
	localparam xlen_t MEIE0_WMASK   = xlen_t'((64'd1 << NUM_IRQ) - 64'd1);

	logic       mstatus_mie;
	logic       mstatus_mpie;
	xlen_t      mtvec;
	xlen_t      mepc;
	logic       mcause_irq;
	logic [5:0] mcause_code;
	xlen_t      mie;
	xlen_t      meie0;

	logic  trap_entry;   // Real trap, not MRET
	logic  trap_exit;    // MRET handshake
	xlen_t mstatus_view; // Packed into CSR layout for the update function
	xlen_t mstatus_new;
	xlen_t mcause_view;
	xlen_t mcause_new;

	assign trap_entry = trap_take && except != EXCEPT_MRET;
	assign trap_exit  = trap_take && except == EXCEPT_MRET;

	always_comb begin
		mstatus_view    = '0;
		mstatus_view[7] = mstatus_mpie;
		mstatus_view[3] = mstatus_mie;
		mcause_view      = '0;
		mcause_view[31]  = mcause_irq;
		mcause_view[5:0] = mcause_code;
	end

	assign mstatus_new = csr_update(mstatus_view, req.wdata, req.wtype, MSTATUS_WMASK);
	assign mcause_new  = csr_update(mcause_view, req.wdata, req.wtype, MCAUSE_WMASK);

	// --------------------
	// Interrupt enable stack
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			mstatus_mie  <= 1'b0;
			mstatus_mpie <= 1'b0;
		end else if (trap_entry) begin
			mstatus_mpie <= mstatus_mie; // Stack and mask
			mstatus_mie  <= 1'b0;
		end else if (trap_exit) begin
			mstatus_mie  <= mstatus_mpie;
			mstatus_mpie <= 1'b1;
		end else if (req.wen && req.addr == ADDR_MSTATUS) begin
			mstatus_mpie <= mstatus_new[7];
			mstatus_mie  <= mstatus_new[3];
		end
	end

	// Trap PC and cause, loaded on entry only
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			mepc        <= '0;
			mcause_irq  <= 1'b0;
			mcause_code <= '0;
		end else if (trap_entry) begin
			mepc        <= mepc_in & MEPC_WMASK;
			mcause_irq  <= cause_irq_next;
			mcause_code <= cause_code_next;
		end else begin
			if (req.wen && req.addr == ADDR_MEPC)
				mepc <= csr_update(mepc, req.wdata, req.wtype, '1) & MEPC_WMASK;
			if (req.wen && req.addr == ADDR_MCAUSE) begin
				mcause_irq  <= mcause_new[31];
				mcause_code <= mcause_new[5:0];
			end
		end
	end

	// --------------------
	// Software-only registers
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			mtvec <= MTVEC_INIT & MTVEC_WMASK;
			mie   <= '0;
			meie0 <= '0;    // All external IRQs masked out of reset
		end else if (req.wen) begin
			if (req.addr == ADDR_MTVEC)
				mtvec <= csr_update(mtvec, req.wdata, req.wtype, MTVEC_WMASK);
			if (req.addr == ADDR_MIE)
				mie <= csr_update(mie, req.wdata, req.wtype, MIE_WMASK);
			if (req.addr == ADDR_MEIE0)
				meie0 <= csr_update(meie0, req.wdata, req.wtype, MEIE0_WMASK);
		end
	end

	always_comb begin
		state.mstatus_mie   = mstatus_mie;
		state.mstatus_mpie  = mstatus_mpie;
		state.mtvec         = mtvec;
		state.vector_enable = mtvec[0]; // MODE 1 is vectored
		state.mepc          = mepc;
		state.mcause_irq    = mcause_irq;
		state.mcause_code   = mcause_code;
		state.mie           = mie;
		state.meie0         = meie0;
	end

endmodule

// ==== source/csr_counters.sv ====
// Cycle and retired-instruction counters, full 64 bits each
// A write to either half replaces the increment for that half in that cycle
// mcountinhibit bit 0 stops mcycle, bit 2 stops minstret
`timescale 1ns/10ps

module csr_counters (
	input  logic              clk,
	input  logic              rst_n,
	input  csr_pkg::csr_req_t req,
	input  logic              instr_ret,
	output logic [63:0]       mcycle,
	output logic [63:0]       minstret,
	output logic [1:0]        inhibit   // {IR, CY}
);
	import csr_pkg::*;

	logic  inhibit_cy;
	logic  inhibit_ir;
	xlen_t inhibit_view;
	xlen_t inhibit_new;

	// Increment, then let a software write override the addressed half
	function automatic logic [63:0] counter_next(logic [63:0] cnt, logic inc,
		logic wr_lo, logic wr_hi, csr_req_t r);
		logic [63:0] nxt;
		nxt = inc ? cnt + 64'd1 : cnt;
		if (wr_lo)
			nxt[31:0] = csr_update(cnt[31:0], r.wdata, r.wtype, '1);
		if (wr_hi)
			nxt[63:32] = csr_update(cnt[63:32], r.wdata, r.wtype, '1);
		return nxt;
	endfunction

	assign inhibit_view = {29'd0, inhibit_ir, 1'b0, inhibit_cy};
	assign inhibit_new  = csr_update(inhibit_view, req.wdata, req.wtype, 32'h0000_0005);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			mcycle     <= '0;
			minstret   <= '0;
			inhibit_cy <= 1'b0;  // Counting from reset
			inhibit_ir <= 1'b0;
		end else begin
			mcycle <= counter_next(mcycle, !inhibit_cy,
				req.wen && req.addr == ADDR_MCYCLE,
				req.wen && req.addr == ADDR_MCYCLEH, req);
			minstret <= counter_next(minstret, !inhibit_ir && instr_ret,
				req.wen && req.addr == ADDR_MINSTRET,
				req.wen && req.addr == ADDR_MINSTRETH, req);
			if (req.wen && req.addr == ADDR_MCOUNTINHIBIT) begin
				inhibit_ir <= inhibit_new[2];
				inhibit_cy <= inhibit_new[0];
			end
		end
	end

	assign inhibit = {inhibit_ir, inhibit_cy};

endmodule

// ==== source/irq_arbiter.sv ====
// Interrupt registering, priority selection and trap request
// Lowest interrupt number wins in both the standard and external sets
// Interrupts only request a trap while mstatus.MIE is set
// mip.MEIP always takes part in the standard interrupts
`timescale 1ns/10ps

module irq_arbiter #(
	parameter int NUM_IRQ = 8
) (
	input  logic                 clk,
	input  logic                 rst_n,
	input  csr_pkg::except_t     except,
	input  logic [NUM_IRQ-1:0]   irq,
	input  logic                 irq_software,
	input  logic                 irq_timer,
	input  logic                 trap_enter_ready,
	input  csr_pkg::trap_state_t state,
	output csr_pkg::xlen_t       mip,
	output csr_pkg::xlen_t       meip0,
	output logic [4:0]           mlei,
	output logic                 trap_take,
	output logic                 cause_irq_next,
	output logic [5:0]           cause_code_next,
	output csr_pkg::xlen_t       trap_addr,
	output logic                 trap_is_irq,
	output logic                 trap_enter_valid
);
	import csr_pkg::*;

	logic [NUM_IRQ-1:0] irq_r;
	logic               irq_software_r;
	logic               irq_timer_r;

	logic       ext_pending;     // Any enabled external line pending
	logic       std_active;
	logic       ext_active;
	logic       except_any;
	logic [4:0] std_num;
	logic [4:0] ext_num;
	logic [5:0] vector_sel;      // Vector table index

	// Lowest set bit, scanned downward so the last hit is the lowest
	function automatic logic [4:0] lowest_set(xlen_t req);
		logic [4:0] gnt;
		gnt = '0;
		for (int i = XLEN - 1; i >= 0; i--) begin
			if (req[i])
				gnt = 5'(i);
		end
		return gnt;
	endfunction

	// --------------------
	// Input registers
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			irq_r          <= '0;
			irq_software_r <= 1'b0;
			irq_timer_r    <= 1'b0;
		end else begin
			irq_r          <= irq;
			irq_software_r <= irq_software;
			irq_timer_r    <= irq_timer;
		end
	end

	assign meip0       = xlen_t'(irq_r);          // Zero-extended
	assign ext_pending = |(state.meie0 & meip0);

	always_comb begin
		mip     = '0;
		mip[11] = ext_pending;      // MEIP
		mip[7]  = irq_timer_r;      // MTIP
		mip[3]  = irq_software_r;   // MSIP
	end

	// --------------------
	// Priority and request
	assign std_active = |(mip & state.mie) && state.mstatus_mie;
	assign ext_active = ext_pending && state.mie[11] && state.mstatus_mie;
	assign std_num    = lowest_set(mip & state.mie);
	assign ext_num    = lowest_set(state.meie0 & meip0);
	assign mlei       = ext_num;

	assign except_any = except != EXCEPT_NONE;

	always_comb begin
		if (except_any || !state.vector_enable)
			vector_sel = 6'd0;
		else if (std_active)
			vector_sel = {1'b0, std_num};
		else if (ext_active)
			vector_sel = {1'b0, ext_num} + 6'd16;
		else
			vector_sel = 6'd0;
	end

	assign trap_enter_valid = except_any || std_active || ext_active;
	assign trap_take        = trap_enter_valid && trap_enter_ready;
	assign trap_is_irq      = !except_any;

	// MRET jumps back, everything else goes through mtvec
	assign trap_addr = (except == EXCEPT_MRET) ? state.mepc :
		{state.mtvec[XLEN-1:2], 2'b00} | {24'd0, vector_sel, 2'b00};

	assign cause_irq_next  = !except_any;
	assign cause_code_next = except_any ? {2'b00, except} : vector_sel;

endmodule

// ==== source/csr_read_decode.sv ====
// CSR read multiplexer and unmapped-address detection
// Purely combinational, illegal only rises during an access
// meip0 and mlei are read-only, writes to mip are accepted and dropped
`timescale 1ns/10ps

module csr_read_decode (
	input  csr_pkg::csr_req_t    req,
	input  csr_pkg::trap_state_t state,
	input  csr_pkg::xlen_t       mip,
	input  csr_pkg::xlen_t       meip0,
	input  logic [4:0]           mlei,
	input  logic [63:0]          mcycle,
	input  logic [63:0]          minstret,
	input  logic [1:0]           inhibit,  // {IR, CY}
	output csr_pkg::xlen_t       rdata,
	output logic                 illegal
);
	import csr_pkg::*;

	logic decode_match; // Address maps to a CSR for this access type

	always_comb begin
		decode_match = 1'b0;
		rdata        = '0;
		case (req.addr)
			// --------------------
			// Trap setup and handling
			ADDR_MSTATUS: begin
				decode_match = 1'b1;
				rdata[12:11] = 2'b11;              // MPP, always M-mode
				rdata[7]     = state.mstatus_mpie;
				rdata[3]     = state.mstatus_mie;
			end
			ADDR_MIE: begin
				decode_match = 1'b1;
				rdata        = state.mie;
			end
			ADDR_MTVEC: begin
				decode_match = 1'b1;
				rdata        = state.mtvec;        // BASE and MODE
			end
			ADDR_MEPC: begin
				decode_match = 1'b1;
				rdata        = state.mepc;
			end
			ADDR_MCAUSE: begin
				decode_match = 1'b1;
				rdata[31]    = state.mcause_irq;
				rdata[4:0]   = state.mcause_code[4:0];
			end
			ADDR_MTVAL: begin
				decode_match = 1'b1;               // Hardwired zero
			end
			ADDR_MIP: begin
				decode_match = 1'b1;
				rdata        = mip;
			end

			// --------------------
			// Counters
			ADDR_MCOUNTINHIBIT: begin
				decode_match = 1'b1;
				rdata[2]     = inhibit[1];
				rdata[0]     = inhibit[0];
			end
			ADDR_MCYCLE: begin
				decode_match = 1'b1;
				rdata        = mcycle[31:0];
			end
			ADDR_MCYCLEH: begin
				decode_match = 1'b1;
				rdata        = mcycle[63:32];
			end
			ADDR_MINSTRET: begin
				decode_match = 1'b1;
				rdata        = minstret[31:0];
			end
			ADDR_MINSTRETH: begin
				decode_match = 1'b1;
				rdata        = minstret[63:32];
			end

			// --------------------
			// External interrupt controller
			ADDR_MEIE0: begin
				decode_match = 1'b1;
				rdata        = state.meie0;
			end
			ADDR_MEIP0: begin
				decode_match = !req.wen;           // Read-only
				rdata        = meip0;
			end
			ADDR_MLEI: begin
				decode_match = !req.wen;           // Read-only
				rdata[4:0]   = mlei;
			end
			default: begin
				decode_match = 1'b0;
			end
		endcase
	end

	assign illegal = (req.wen || req.ren) && !decode_match;

endmodule

// ==== source/csr_top.sv ====
// Machine-mode CSR block for a single-hart RV32 core
// CSR reads are combinational, writes land at the next rising edge
// Interrupt lines are registered once before they can raise a trap
// NUM_IRQ must lie between 1 and 32
`timescale 1ns/10ps

module csr_top #(
	parameter int            NUM_IRQ    = 8,
	parameter csr_pkg::xlen_t MTVEC_INIT = '0
) (
	input  logic              clk,
	input  logic              rst_n,
	// CSR access port
	input  csr_pkg::csr_req_t req,
	output csr_pkg::xlen_t    rdata,
	output logic              illegal,
	// Core events
	input  csr_pkg::except_t  except,
	input  logic [NUM_IRQ-1:0] irq,
	input  logic              irq_software,
	input  logic              irq_timer,
	input  logic              instr_ret,
	input  csr_pkg::xlen_t    mepc_in,
	// Trap handshake
	output csr_pkg::xlen_t    trap_addr,
	output logic              trap_is_irq,
	output logic              trap_enter_valid,
	input  logic              trap_enter_ready
);
	import csr_pkg::*;

	trap_state_t trap_state;      // Trap CSRs as seen by arbiter and read mux
	logic        trap_take;       // Handshake completes this edge
	logic        cause_irq_next;
	logic [5:0]  cause_code_next;
	xlen_t       mip;
	xlen_t       meip0;
	logic [4:0]  mlei;
	logic [63:0] mcycle;
	logic [63:0] minstret;
	logic [1:0]  inhibit;         // {IR, CY}

	csr_trap_regs #(
		.NUM_IRQ    (NUM_IRQ),
		.MTVEC_INIT (MTVEC_INIT)
	) trap_regs_inst (
		.clk             (clk),
		.rst_n           (rst_n),
		.req             (req),
		.except          (except),
		.mepc_in         (mepc_in),
		.trap_take       (trap_take),
		.cause_irq_next  (cause_irq_next),
		.cause_code_next (cause_code_next),
		.state           (trap_state)
	);

	csr_counters counters_inst (
		.clk       (clk),
		.rst_n     (rst_n),
		.req       (req),
		.instr_ret (instr_ret),
		.mcycle    (mcycle),
		.minstret  (minstret),
		.inhibit   (inhibit)
	);

	irq_arbiter #(
		.NUM_IRQ (NUM_IRQ)
	) irq_arbiter_inst (
		.clk              (clk),
		.rst_n            (rst_n),
		.except           (except),
		.irq              (irq),
		.irq_software     (irq_software),
		.irq_timer        (irq_timer),
		.trap_enter_ready (trap_enter_ready),
		.state            (trap_state),
		.mip              (mip),
		.meip0            (meip0),
		.mlei             (mlei),
		.trap_take        (trap_take),
		.cause_irq_next   (cause_irq_next),
		.cause_code_next  (cause_code_next),
		.trap_addr        (trap_addr),
		.trap_is_irq      (trap_is_irq),
		.trap_enter_valid (trap_enter_valid)
	);

	csr_read_decode read_decode_inst (
		.req      (req),
		.state    (trap_state),
		.mip      (mip),
		.meip0    (meip0),
		.mlei     (mlei),
		.mcycle   (mcycle),
		.minstret (minstret),
		.inhibit  (inhibit),
		.rdata    (rdata),
		.illegal  (illegal)
	);

endmodule

// ==== sim/csr_assertions.sv ====
// Concurrent checks on the trap request and on mstatus.MIE
// Bound into csr_top, all properties are off while rst_n is low
// Each property keeps a failure count next to its $error
`timescale 1ns/10ps

module csr_assertions (
	input logic                 clk,
	input logic                 rst_n,
	input csr_pkg::except_t     except,
	input csr_pkg::trap_state_t trap_state,
	input logic                 trap_take,
	input logic                 trap_enter_valid,
	input logic                 trap_is_irq
);
	import csr_pkg::*;

	int idle_valid_fails = 0;
	int irq_except_fails = 0;
	int mie_clear_fails  = 0;

	logic no_irq_enabled; // Global or every local enable off

	assign no_irq_enabled = !trap_state.mstatus_mie || trap_state.mie == '0;

	// --------------------
	// Request only with a source
	idle_valid_low: assert property (@(posedge clk) disable iff (!rst_n)
		(except == EXCEPT_NONE && no_irq_enabled) |-> !trap_enter_valid)
	else begin
		idle_valid_fails++;
		$error("trap_enter_valid high with no exception and no enabled interrupt");
	end

	// Exceptions are never flagged as interrupts
	irq_flag_clean: assert property (@(posedge clk) disable iff (!rst_n)
		(except != EXCEPT_NONE) |-> !trap_is_irq)
	else begin
		irq_except_fails++;
		$error("trap_is_irq high during an exception");
	end

	// --------------------
	// Trap entry masks interrupts
	mie_cleared: assert property (@(posedge clk) disable iff (!rst_n)
		(trap_take && except != EXCEPT_MRET) |=> !trap_state.mstatus_mie)
	else begin
		mie_clear_fails++;
		$error("mstatus.MIE still set in the cycle after trap entry");
	end

endmodule

bind csr_top csr_assertions csr_assertions_inst (
	.clk              (clk),
	.rst_n            (rst_n),
	.except           (except),
	.trap_state       (trap_state),
	.trap_take        (trap_take),
	.trap_enter_valid (trap_enter_valid),
	.trap_is_irq      (trap_is_irq)
);

// ==== sim/csr_tb.sv ====
// Directed and seeded-random testbench for the machine-mode CSR block
// Built for NUM_IRQ 8 and MTVEC_INIT 0, mtvec bases stay 256-byte aligned
// Inputs change on the falling edge, outputs are sampled 5 ns later
`timescale 1ns/10ps

module csr_tb;
	import csr_pkg::*;

	localparam int    NUM_IRQ     = 8;
	localparam int    CYCLE_LIMIT = 2000;          // About ten times the directed run
	localparam xlen_t MIE_MASK    = 32'h0000_0888; // MEIE, MTIE, MSIE
	localparam xlen_t MTVEC_MASK  = 32'hffff_fffd; // Bit 1 reads 0
	localparam xlen_t MEPC_MASK   = 32'hffff_fffe; // Bit 0 reads 0
	localparam xlen_t MEIE0_MASK  = 32'h0000_00ff; // One bit per IRQ line

	logic               clk;
	logic               rst_n;
	csr_req_t           req;
	xlen_t              rdata;
	logic               illegal;
	except_t            except;
	logic [NUM_IRQ-1:0] irq;
	logic               irq_software;
	logic               irq_timer;
	logic               instr_ret;
	xlen_t              mepc_in;
	xlen_t              trap_addr;
	logic               trap_is_irq;
	logic               trap_enter_valid;
	logic               trap_enter_ready;

	int        mismatches;
	int        stall_errors;      // Handshake waits that ran out
	int        cycle_count = 0;
	xlen_t     model [4];         // Expected mie, mtvec, mepc, meie0
	csr_addr_t map_addr [4];
	xlen_t     map_mask [4];

	csr_top #(
		.NUM_IRQ    (NUM_IRQ),
		.MTVEC_INIT (32'h0)
	) csr_top_inst (
		.clk              (clk),
		.rst_n            (rst_n),
		.req              (req),
		.rdata            (rdata),
		.illegal          (illegal),
		.except           (except),
		.irq              (irq),
		.irq_software     (irq_software),
		.irq_timer        (irq_timer),
		.instr_ret        (instr_ret),
		.mepc_in          (mepc_in),
		.trap_addr        (trap_addr),
		.trap_is_irq      (trap_is_irq),
		.trap_enter_valid (trap_enter_valid),
		.trap_enter_ready (trap_enter_ready)
	);

	always #20 clk = ~clk; // 40 ns period

	// --------------------
	// Reference rules
	function automatic xlen_t merge_write(xlen_t old, xlen_t data, wtype_t wt, xlen_t mask);
		xlen_t raw;
		if (wt == WTYPE_S)
			raw = old | data;
		else if (wt == WTYPE_C)
			raw = old & ~data;
		else
			raw = data;
		return (raw & mask) | (old & ~mask); // Masked bits hold
	endfunction

	function automatic logic [4:0] lowest_pending(xlen_t bits);
		int idx;
		idx = 0;
		while (idx < 31 && !bits[idx])
			idx++;
		return (bits == '0) ? 5'd0 : 5'(idx);
	endfunction

	function automatic logic is_mapped(csr_addr_t a);
		case (a)
			12'h300, 12'h304, 12'h305, 12'h320, 12'h341, 12'h342, 12'h343, 12'h344,
			12'hb00, 12'hb02, 12'hb80, 12'hb82, 12'hbe0, 12'hfe0, 12'hfe4: return 1'b1;
			default: return 1'b0;
		endcase
	endfunction

	function automatic csr_req_t make_req(csr_addr_t a, xlen_t d, wtype_t wt, logic wr,
		logic rd);
		csr_req_t r;
		r.addr  = a;
		r.wdata = d;
		r.wtype = wt;
		r.wen   = wr;
		r.ren   = rd;
		return r;
	endfunction

	// --------------------
	// Checks
	task automatic check_value(input string what, input xlen_t got, input xlen_t exp);
		if (got !== exp) begin
			mismatches++;
			$display("mismatch at %0d ns: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_bit(input string what, input logic got, input logic exp);
		if (got !== exp) begin
			mismatches++;
			$display("mismatch at %0d ns: %s is %b, expected %b", $time, what, got, exp);
		end
	endtask

	// Bus tasks start and end on a falling edge with the port idle
	task automatic write_csr(input csr_addr_t a, input xlen_t d, input wtype_t wt);
		req = make_req(a, d, wt, 1'b1, 1'b0);
		#5;
		check_bit("illegal on mapped write", illegal, 1'b0);
		@(negedge clk);
		req = make_req(12'h000, '0, WTYPE_W, 1'b0, 1'b0);
	endtask

	task automatic expect_csr(input csr_addr_t a, input xlen_t exp, input string what);
		req = make_req(a, '0, WTYPE_W, 1'b0, 1'b1);
		#5;
		check_value(what, rdata, exp);
		check_bit("illegal on mapped read", illegal, 1'b0);
		@(negedge clk);
		req = make_req(12'h000, '0, WTYPE_W, 1'b0, 1'b0);
	endtask

	task automatic probe_illegal(input csr_addr_t a, input logic rd, input logic wr,
		input logic exp);
		req = make_req(a, $urandom, WTYPE_W, wr, rd);
		#5;
		check_bit("illegal", illegal, exp);
		@(negedge clk);
		req = make_req(12'h000, '0, WTYPE_W, 1'b0, 1'b0);
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) @(negedge clk);
	endtask

	task automatic wait_valid(input int limit);
		int waited;
		waited = 0;
		while (!trap_enter_valid && waited < limit) begin
			@(negedge clk);
			waited++;
		end
		if (!trap_enter_valid) begin
			stall_errors++;
			$display("trap_enter_valid did not rise within %0d cycles at %0d ns", limit, $time);
		end
	endtask

	task automatic take_trap();
		trap_enter_ready = 1'b1; // Handshake on the next rising edge
		@(negedge clk);
		trap_enter_ready = 1'b0;
	endtask

	task automatic mret_return();
		except           = EXCEPT_MRET;
		trap_enter_ready = 1'b1;
		@(negedge clk);
		trap_enter_ready = 1'b0;
		except           = EXCEPT_NONE;
	endtask

	// --------------------
	// Stimulus
	initial begin
		int unsigned seed_dummy;
		xlen_t       wval;
		xlen_t       base;
		xlen_t       irq_val;
		csr_addr_t   a;
		logic [1:0]  sel;
		logic [1:0]  wt_sel;
		wtype_t      wt;
		except_t     exc;
		int          hold;
		int          n;
		int          assert_fails;

		seed_dummy       = $urandom(32'h04f5_cbdc);
		clk              = 1'b0;
		rst_n            = 1'b0;
		req              = make_req(12'h000, '0, WTYPE_W, 1'b0, 1'b0);
		except           = EXCEPT_NONE;
		irq              = '0;
		irq_software     = 1'b0;
		irq_timer        = 1'b0;
		instr_ret        = 1'b0;
		mepc_in          = '0;
		trap_enter_ready = 1'b0;
		mismatches       = 0;
		stall_errors     = 0;
		model            = '{32'h0, 32'h0, 32'h0, 32'h0};
		map_addr         = '{12'h304, 12'h305, 12'h341, 12'hbe0};
		map_mask         = '{MIE_MASK, MTVEC_MASK, MEPC_MASK, MEIE0_MASK};

		repeat (8) @(negedge clk);
		rst_n = 1'b1;
		check_bit("trap_enter_valid after reset", trap_enter_valid, 1'b0);
		check_bit("illegal after reset", illegal, 1'b0);
		expect_csr(12'h300, 32'h0000_1800, "mstatus after reset"); // MPP only
		expect_csr(12'h320, 32'h0, "mcountinhibit after reset");

		// Masked write, set and clear with random data
		for (int i = 0; i < 24; i++) begin
			sel      = 2'($urandom_range(0, 3));
			wt_sel   = 2'($urandom_range(0, 2));
			wt       = wtype_t'(wt_sel);
			wval     = $urandom;
			model[sel] = merge_write(model[sel], wval, wt, map_mask[sel]);
			write_csr(map_addr[sel], wval, wt);
			expect_csr(map_addr[sel], model[sel], "masked CSR update");
		end
		write_csr(12'h341, 32'h0000_0001, WTYPE_S); // Setting a fixed-zero bit has no effect
		expect_csr(12'h341, model[2] & MEPC_MASK, "mepc low bit");
		write_csr(12'h305, 32'h0000_0002, WTYPE_S);
		expect_csr(12'h305, model[1] & MTVEC_MASK, "mtvec bit 1");

		// Illegal access detection
		probe_illegal(12'h340, 1'b1, 1'b0, 1'b1); // mscratch dropped
		probe_illegal(12'h301, 1'b1, 1'b0, 1'b1); // misa dropped
		probe_illegal(12'hf11, 1'b1, 1'b0, 1'b1);
		probe_illegal(12'hb03, 1'b1, 1'b0, 1'b1); // hpm counter
		probe_illegal(12'hfe4, 1'b0, 1'b1, 1'b1); // mlei is read-only
		probe_illegal(12'hfe0, 1'b0, 1'b1, 1'b1);
		probe_illegal(12'hfe4, 1'b1, 1'b0, 1'b0);
		probe_illegal(12'h300, 1'b1, 1'b0, 1'b0);
		probe_illegal(12'h340, 1'b0, 1'b0, 1'b0); // No access, no flag
		for (int i = 0; i < 16; i++) begin
			a = 12'($urandom);
			probe_illegal(a, 1'b1, 1'b0, !is_mapped(a));
		end

		// --------------------
		// Exception under back-pressure, then MRET
		write_csr(12'h304, 32'h0, WTYPE_W);
		model[0] = '0;
		base = $urandom & 32'hffff_ff00;
		write_csr(12'h305, base, WTYPE_W);    // Direct mode
		model[1] = base;
		write_csr(12'h300, 32'h0000_0008, WTYPE_W); // MIE on, MPIE off
		exc     = except_t'(4'($urandom_range(0, 7)));
		mepc_in = $urandom;
		except  = exc;
		hold    = $urandom_range(3, 8);
		for (int i = 0; i < hold; i++) begin
			case (i % 3)
				0: req = make_req(12'h300, '0, WTYPE_W, 1'b0, 1'b1);
				1: req = make_req(12'h341, '0, WTYPE_W, 1'b0, 1'b1);
				default: req = make_req(12'h342, '0, WTYPE_W, 1'b0, 1'b1);
			endcase
			#5;
			case (i % 3)
				0: check_value("mstatus while stalled", rdata, 32'h0000_1808);
				1: check_value("mepc while stalled", rdata, model[2]);
				default: check_value("mcause while stalled", rdata, 32'h0);
			endcase
			check_bit("valid while stalled", trap_enter_valid, 1'b1);
			check_bit("trap_is_irq on exception", trap_is_irq, 1'b0);
			check_value("trap_addr on exception", trap_addr, base);
			@(negedge clk);
		end
		req = make_req(12'h000, '0, WTYPE_W, 1'b0, 1'b0);
		take_trap();
		except   = EXCEPT_NONE;
		model[2] = mepc_in & MEPC_MASK;
		expect_csr(12'h341, model[2], "mepc after exception");
		expect_csr(12'h342, {28'd0, exc}, "mcause after exception");
		expect_csr(12'h300, 32'h0000_1880, "mstatus after exception");
		check_bit("valid after exception", trap_enter_valid, 1'b0);
		except = EXCEPT_MRET;
		#5;
		check_value("trap_addr on MRET", trap_addr, model[2]);
		check_bit("valid on MRET", trap_enter_valid, 1'b1);
		@(negedge clk);
		trap_enter_ready = 1'b1;
		@(negedge clk);
		trap_enter_ready = 1'b0;
		except           = EXCEPT_NONE;
		expect_csr(12'h300, 32'h0000_1888, "mstatus after MRET");

		// --------------------
		// Vectored interrupts
		base = $urandom & 32'hffff_ff00;
		write_csr(12'h305, base | 32'h1, WTYPE_W);
		write_csr(12'h304, 32'h0000_0080, WTYPE_W); // MTIE only
		mepc_in   = $urandom;
		irq_timer = 1'b1;
		wait_valid(8);
		check_value("trap_addr for timer", trap_addr, base + 32'd28);
		check_bit("trap_is_irq for timer", trap_is_irq, 1'b1);
		take_trap();
		irq_timer = 1'b0;
		expect_csr(12'h342, 32'h8000_0007, "mcause for timer");
		expect_csr(12'h341, mepc_in & MEPC_MASK, "mepc for timer");
		expect_csr(12'h300, 32'h0000_1880, "mstatus in timer handler");
		mret_return();
		expect_csr(12'h300, 32'h0000_1888, "mstatus after timer MRET");
		write_csr(12'h304, 32'h0, WTYPE_W);

		// External lines with MEIE off, only mlei and meip0 react
		wval = ($urandom & MEIE0_MASK) | (32'h1 << $urandom_range(0, 7));
		write_csr(12'hbe0, wval, WTYPE_W);
		model[3] = wval;
		for (int i = 0; i < 6; i++) begin
			irq_val = $urandom;
			irq     = irq_val[NUM_IRQ-1:0];
			idle_cycles(1);                       // Through the input register
			expect_csr(12'hfe0, {24'd0, irq}, "meip0");
			expect_csr(12'hfe4, {27'd0, lowest_pending(model[3] & {24'd0, irq})}, "mlei");
		end
		irq = model[3][NUM_IRQ-1:0];
		idle_cycles(1);
		write_csr(12'h304, 32'h0000_0800, WTYPE_W); // MEIE, standard bit 11
		wait_valid(8);
		check_value("trap_addr for MEIP", trap_addr, base + 32'd44);
		take_trap();
		irq = '0;
		expect_csr(12'h342, 32'h8000_000b, "mcause for MEIP");
		mret_return();
		write_csr(12'h304, 32'h0, WTYPE_W);

		// --------------------
		// Counters
		wval = $urandom & 32'h7fff_ffff;      // No carry into mcycleh
		write_csr(12'hb00, wval, WTYPE_W);
		expect_csr(12'hb00, wval, "mcycle after write");
		n = $urandom_range(2, 10);
		idle_cycles(n);
		expect_csr(12'hb00, wval + 32'(n) + 32'd1, "mcycle after counting");
		irq_val = $urandom;
		write_csr(12'hb80, irq_val, WTYPE_W);
		expect_csr(12'hb80, irq_val, "mcycleh after write");
		write_csr(12'h320, 32'h1, WTYPE_W);   // Stop cycles
		expect_csr(12'h320, 32'h1, "mcountinhibit");
		wval = $urandom;
		write_csr(12'hb00, wval, WTYPE_W);
		expect_csr(12'hb00, wval, "inhibited mcycle after write");
		idle_cycles($urandom_range(2, 6));
		expect_csr(12'hb00, wval, "inhibited mcycle");
		write_csr(12'h320, 32'h0, WTYPE_W);
		wval = $urandom & 32'h7fff_ffff;
		write_csr(12'hb02, wval, WTYPE_W);
		n = $urandom_range(3, 9);
		for (int i = 0; i < n; i++) begin
			instr_ret = 1'b1;
			@(negedge clk);
			instr_ret = 1'b0;
			idle_cycles($urandom_range(0, 2));
		end
		expect_csr(12'hb02, wval + 32'(n), "minstret");

		idle_cycles(2);
		assert_fails = csr_top_inst.csr_assertions_inst.idle_valid_fails +
			csr_top_inst.csr_assertions_inst.irq_except_fails +
			csr_top_inst.csr_assertions_inst.mie_clear_fails;
		$display("Error counts: %0d mismatches, %0d handshake timeouts, %0d assertion failures",
			mismatches, stall_errors, assert_fails);
		if (mismatches == 0 && stall_errors == 0 && assert_fails == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

	// Run limit
	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= CYCLE_LIMIT) begin
			$display("Run stopped after %0d cycles without reaching the end", CYCLE_LIMIT);
			$display("Error counts: %0d mismatches, %0d handshake timeouts, run timed out",
				mismatches, stall_errors);
			$display("Testbench failed");
			$finish;
		end
	end

endmodule

// ==== tb.f ====
source/csr_pkg.sv
source/csr_trap_regs.sv
source/csr_counters.sv
source/irq_arbiter.sv
source/csr_read_decode.sv
source/csr_top.sv
sim/csr_assertions.sv
sim/csr_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the CSR block testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -f tb.f --top-module csr_tb -o csr_sim

# Keep running past the first assertion error so the testbench gives its verdict
./obj_dir/csr_sim +verilator+error+limit+1000 | tee "$LOG"

if grep -q "Testbench failed" "$LOG"; then
	echo "Result: FAIL"
	exit 1
fi
if ! grep -q "Testbench passed" "$LOG"; then
	echo "Result: FAIL, no verdict in $LOG"
	exit 1
fi
echo "Result: PASS"
